// ==== src/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Data path widths
`define CONV_DATA_WIDTH      16
`define CONV_WEIGHT_WIDTH    8
`define CONV_ACC_WIDTH       40

// Frame geometry
`define CONV_IMAGE_WIDTH     4
`define CONV_IMAGE_SIZE      16
`define CONV_CHANNEL_NUM_IN  3
`define CONV_CHANNEL_NUM_OUT 4

// Idle gap scaling between replay passes
`define CONV_RATE            1

// Derived sizes
`define CONV_FRAME_PIXELS    (`CONV_CHANNEL_NUM_IN * `CONV_IMAGE_SIZE)
`define CONV_GAP_CYCLES      ((`CONV_IMAGE_WIDTH * `CONV_RATE) + `CONV_RATE)

`endif

// ==== src/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

	////////////////////
	// Data types

	// Pixels are unsigned, weights signed
	typedef logic [`CONV_DATA_WIDTH-1:0] pixel_t;
	typedef logic signed [`CONV_WEIGHT_WIDTH-1:0] weight_t;

	// Zero-extended pixel times weight
	typedef logic signed [`CONV_DATA_WIDTH+`CONV_WEIGHT_WIDTH:0] product_t;
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	////////////////////
	// Index types

	// Frame RAM address
	typedef logic [$clog2(`CONV_FRAME_PIXELS)-1:0] frame_addr_t;
	typedef logic [$clog2(`CONV_CHANNEL_NUM_IN)-1:0] chan_in_t;
	typedef logic [$clog2(`CONV_CHANNEL_NUM_OUT)-1:0] chan_out_t;

	// Pass times channel count plus channel
	typedef logic [$clog2(`CONV_CHANNEL_NUM_OUT*`CONV_CHANNEL_NUM_IN)-1:0]
		weight_addr_t;

endpackage

// ==== src/replay_if.sv ====
`timescale 1ns/1ps

// One replayed pixel per strobe, no handshake
interface replay_if;

	// Single-cycle strobe per pixel
	logic                valid;
	conv_pkg::pixel_t    data;

	// Input channel of this pixel
	conv_pkg::chan_in_t  chan_in;

	// Output channel being produced
	conv_pkg::chan_out_t pass;

	// Final pixel of the pass
	logic                last;

	modport source (
		output valid,
		output data,
		output chan_in,
		output pass,
		output last
	);

	modport sink (
		input valid,
		input data,
		input chan_in,
		input pass,
		input last
	);

endinterface

// ==== src/single_port_ram.sv ====
`timescale 1ns/1ps

module single_port_ram #(
	parameter type payload_t = conv_pkg::pixel_t,
	parameter int  DEPTH     = 16
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  payload_t                 wdata,
	output payload_t                 rdata
);

	payload_t mem [DEPTH];

	// Registered read, written word shows up on rdata the next cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
				rdata     <= wdata;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== src/feature_loop_buffer.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module feature_loop_buffer (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  conv_pkg::pixel_t pxl_in,
	output logic             done,
	replay_if.source         out
);

	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_gap,
		st_replay,
		st_done
	} phase_t;

	phase_t                                  phase;
	conv_pkg::frame_addr_t                   addr_cnt;
	logic [$clog2(`CONV_IMAGE_SIZE)-1:0]     pix_cnt;
	conv_pkg::chan_in_t                      chan_cnt;
	conv_pkg::chan_out_t                     pass_cnt;
	logic [$clog2(`CONV_GAP_CYCLES + 1)-1:0] gap_cnt;
	logic                                    issue;
	logic                                    frame_end;

	// RAM access stage
	logic                  s1_valid;
	logic                  s1_we;
	logic                  s1_last;
	conv_pkg::frame_addr_t s1_addr;
	conv_pkg::pixel_t      s1_pxl;
	conv_pkg::chan_in_t    s1_chan;
	conv_pkg::chan_out_t   s1_pass;

	// Read data stage
	logic                  s2_valid;
	logic                  s2_last;
	conv_pkg::chan_in_t    s2_chan;
	conv_pkg::chan_out_t   s2_pass;
	conv_pkg::pixel_t      ram_rdata;

	// One beat per cycle while the frame arrives or a replay runs
	assign issue     = ((phase == st_idle || phase == st_write) && valid_in) ||
		(phase == st_replay);
	assign frame_end = (addr_cnt == `CONV_FRAME_PIXELS - 1);

	////////////////////
	// Sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			phase    <= st_idle;
			addr_cnt <= '0;
			pix_cnt  <= '0;
			chan_cnt <= '0;
			pass_cnt <= '0;
			gap_cnt  <= '0;
		end else if (phase == st_gap) begin
			// Idle cycles before the next replay
			if (gap_cnt == `CONV_GAP_CYCLES - 1)
				phase <= st_replay;
			gap_cnt <= gap_cnt + 1'b1;
		end else if (issue) begin
			if (frame_end) begin
				addr_cnt <= '0;
				pix_cnt  <= '0;
				chan_cnt <= '0;
				gap_cnt  <= '0;
				if (pass_cnt == `CONV_CHANNEL_NUM_OUT - 1) begin
					phase <= st_done;
				end else begin
					phase    <= st_gap;
					pass_cnt <= pass_cnt + 1'b1;
				end
			end else begin
				addr_cnt <= addr_cnt + 1'b1;
				// Channel tag tracks address / IMAGE_SIZE
				if (pix_cnt == `CONV_IMAGE_SIZE - 1) begin
					pix_cnt  <= '0;
					chan_cnt <= chan_cnt + 1'b1;
				end else begin
					pix_cnt <= pix_cnt + 1'b1;
				end
				if (phase == st_idle)
					phase <= st_write;
			end
		end
	end

	////////////////////
	// Tag pipeline

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_we    <= 1'b0;
			s1_last  <= 1'b0;
			s2_valid <= 1'b0;
			s2_last  <= 1'b0;
			done     <= 1'b0;
		end else begin
			s1_valid <= issue;
			s1_we    <= issue && (phase != st_replay);
			s1_last  <= issue && frame_end;
			s2_valid <= s1_valid;
			s2_last  <= s1_last;
			// Sticky until reset
			if (s2_valid && s2_last && (s2_pass == `CONV_CHANNEL_NUM_OUT - 1))
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		s1_pxl  <= pxl_in;
		s1_addr <= addr_cnt;
		s1_chan <= chan_cnt;
		s1_pass <= pass_cnt;
		s2_chan <= s1_chan;
		s2_pass <= s1_pass;
	end

	// Pass 0 goes through the write-first path
	single_port_ram #(
		.payload_t (conv_pkg::pixel_t),
		.DEPTH     (`CONV_FRAME_PIXELS)
	) frame_ram (
		.clk   (clk),
		.en    (s1_valid),
		.we    (s1_we),
		.addr  (s1_addr),
		.wdata (s1_pxl),
		.rdata (ram_rdata)
	);

	assign out.valid   = s2_valid;
	assign out.data    = ram_rdata;
	assign out.chan_in = s2_chan;
	assign out.pass    = s2_pass;
	assign out.last    = s2_last;

endmodule

// ==== src/pass_accumulator.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module pass_accumulator (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   weight_we,
	input  conv_pkg::weight_addr_t weight_addr,
	input  conv_pkg::weight_t      weight_data,
	replay_if.sink                 in,
	output conv_pkg::acc_t         result,
	output logic                   result_valid
);

	conv_pkg::weight_addr_t rd_addr;
	conv_pkg::weight_addr_t ram_addr;
	conv_pkg::weight_t      weight_q;
	logic                   at_start;
	logic                   first_beat;

	// Stage 1, weight read
	logic                   p1_valid;
	logic                   p1_first;
	logic                   p1_last;
	conv_pkg::pixel_t       p1_pxl;

	// Stage 2, product
	logic                   p2_valid;
	logic                   p2_first;
	logic                   p2_last;
	conv_pkg::product_t     p2_prod;

	conv_pkg::acc_t         acc;

	// w[pass][chan] lives at pass * CHANNEL_NUM_IN + chan
	assign rd_addr  = conv_pkg::weight_addr_t'(in.pass * `CONV_CHANNEL_NUM_IN + in.chan_in);
	assign ram_addr = weight_we ? weight_addr : rd_addr;

	single_port_ram #(
		.payload_t (conv_pkg::weight_t),
		.DEPTH     (`CONV_CHANNEL_NUM_OUT * `CONV_CHANNEL_NUM_IN)
	) weight_ram (
		.clk   (clk),
		.en    (weight_we || in.valid),
		.we    (weight_we),
		.addr  (ram_addr),
		.wdata (weight_data),
		.rdata (weight_q)
	);

	// Next beat after a last opens a new pass
	assign first_beat = in.valid && at_start;

	////////////////////
	// Control pipeline

	always_ff @(posedge clk) begin
		if (reset) begin
			at_start     <= 1'b1;
			p1_valid     <= 1'b0;
			p1_first     <= 1'b0;
			p1_last      <= 1'b0;
			p2_valid     <= 1'b0;
			p2_first     <= 1'b0;
			p2_last      <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			if (in.valid)
				at_start <= in.last;
			p1_valid     <= in.valid;
			p1_first     <= first_beat;
			p1_last      <= in.valid && in.last;
			p2_valid     <= p1_valid;
			p2_first     <= p1_first;
			p2_last      <= p1_last;
			result_valid <= p2_valid && p2_last;
		end
	end

	////////////////////
	// Multiply-accumulate

	always_ff @(posedge clk) begin
		p1_pxl <= in.data;
		// Pixel is unsigned, so extend with a zero sign bit
		p2_prod <= $signed({1'b0, p1_pxl}) * weight_q;
		if (p2_valid) begin
			if (p2_first)
				acc <= p2_prod;
			else
				acc <= acc + p2_prod;
		end
	end

	assign result = acc;

endmodule

// ==== src/conv_loop_top.sv ====
`timescale 1ns/1ps

module conv_loop_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   valid_in,
	input  conv_pkg::pixel_t       pxl_in,
	input  logic                   weight_we,
	input  conv_pkg::weight_addr_t weight_addr,
	input  conv_pkg::weight_t      weight_data,
	output conv_pkg::pixel_t       pxl_out,
	output logic                   valid_out,
	output conv_pkg::acc_t         result,
	output logic                   result_valid,
	output logic                   done
);

	// Buffer to accumulator link
	replay_if replay ();

	feature_loop_buffer u_buffer (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pxl_in   (pxl_in),
		.done     (done),
		.out      (replay.source)
	);

	pass_accumulator u_accumulator (
		.clk          (clk),
		.reset        (reset),
		.weight_we    (weight_we),
		.weight_addr  (weight_addr),
		.weight_data  (weight_data),
		.in           (replay.sink),
		.result       (result),
		.result_valid (result_valid)
	);

	// Replay stream is also visible at the top
	assign pxl_out   = replay.data;
	assign valid_out = replay.valid;

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== testbench/conv_loop_tb.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_loop_tb;

	localparam int FRAME    = `CONV_FRAME_PIXELS;
	localparam int GAP      = `CONV_GAP_CYCLES;
	localparam int NUM_IN   = `CONV_CHANNEL_NUM_IN;
	localparam int NUM_OUT  = `CONV_CHANNEL_NUM_OUT;
	localparam int WATCHDOG = 5 + NUM_OUT * NUM_IN + NUM_OUT * (FRAME + GAP) + 200;

	logic                   clk;
	logic                   reset;
	logic                   valid_in;
	logic                   in_frame;
	conv_pkg::pixel_t       pxl_in;
	logic                   weight_we;
	conv_pkg::weight_addr_t weight_addr;
	conv_pkg::weight_t      weight_data;
	conv_pkg::pixel_t       pxl_out;
	logic                   valid_out;
	conv_pkg::acc_t         result;
	logic                   result_valid;
	logic                   done;

	// Scoreboard state
	conv_pkg::pixel_t  frame [FRAME];
	conv_pkg::weight_t weights [NUM_OUT][NUM_IN];
	longint            exp_res [NUM_OUT];
	int                beat_idx;
	int                pass_idx;
	int                gap_len;
	int                res_idx;
	logic [1:0]        fwd_d;
	logic [2:0]        last_d;
	conv_pkg::pixel_t  exp_pxl;
	longint            exp_cur;
	logic [31:0]       lfsr;
	int                value_errors = 0;
	int                other_errors = 0;

	clock_gen clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	conv_loop_top conv_loop_top_i (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (valid_in),
		.pxl_in       (pxl_in),
		.weight_we    (weight_we),
		.weight_addr  (weight_addr),
		.weight_data  (weight_data),
		.pxl_out      (pxl_out),
		.valid_out    (valid_out),
		.result       (result),
		.result_valid (result_valid),
		.done         (done)
	);

	task report_mismatch(input string name, input longint expected, input longint actual);
		value_errors++;
		$display("FAIL time=%0t %s expected %0d actual %0d", $time, name, expected, actual);
	endtask

	task report_problem(input string what);
		other_errors++;
		$display("ERROR at time %0t: %s", $time, what);
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Dot product of one pass, pixels zero-extended
	function automatic longint pass_sum(input int k);
		longint s;
		s = 0;
		for (int i = 0; i < FRAME; i++)
			s += longint'(frame[i]) * longint'(weights[k][i / `CONV_IMAGE_SIZE]);
		return s;
	endfunction

	////////////////////
	// Scoreboard

	assign exp_pxl = frame[beat_idx];
	assign exp_cur = (res_idx < NUM_OUT) ? exp_res[res_idx] : 64'sd0;

	always @(posedge clk) begin
		if (reset) begin
			beat_idx <= 0;
			pass_idx <= 0;
			gap_len  <= 0;
			res_idx  <= 0;
			fwd_d    <= '0;
			last_d   <= '0;
		end else begin
			fwd_d  <= {fwd_d[0], valid_in && in_frame};
			last_d <= {last_d[1:0], valid_out && beat_idx == FRAME - 1};
			if (valid_out) begin
				gap_len <= 0;
				if (beat_idx == FRAME - 1) begin
					beat_idx <= 0;
					pass_idx <= pass_idx + 1;
				end else begin
					beat_idx <= beat_idx + 1;
				end
			end else if (beat_idx == 0 && pass_idx > 0) begin
				gap_len <= gap_len + 1;
			end
			if (result_valid)
				res_idx <= res_idx + 1;
		end
	end

	////////////////////
	// Checks

	reset_quiet: assert property (@(posedge clk)
		$past(reset) |-> !valid_out && !result_valid && !done)
		else report_mismatch("{valid_out,result_valid,done}", 0,
			$sampled({valid_out, result_valid, done}));

	// Pass 0 output two cycles behind the input
	fwd_timing: assert property (@(posedge clk) disable iff (reset) fwd_d[1] |-> valid_out)
		else report_mismatch("valid_out", 1, $sampled(valid_out));

	pixel_order: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> pxl_out == exp_pxl)
		else report_mismatch("pxl_out", $sampled(exp_pxl), $sampled(pxl_out));

	pass_limit: assert property (@(posedge clk) disable iff (reset)
		valid_out |-> pass_idx < NUM_OUT)
		else report_problem("valid_out beat after the last pass");

	beats_back_to_back: assert property (@(posedge clk) disable iff (reset)
		beat_idx != 0 |-> valid_out)
		else report_problem("valid_out dropped in the middle of a pass");

	gap_exact: assert property (@(posedge clk) disable iff (reset)
		(valid_out && beat_idx == 0 && pass_idx > 0 && pass_idx < NUM_OUT) |-> gap_len == GAP)
		else report_mismatch("gap length", GAP, $sampled(gap_len));

	gap_not_long: assert property (@(posedge clk) disable iff (reset)
		(!valid_out && beat_idx == 0 && pass_idx > 0 && pass_idx < NUM_OUT) |-> gap_len < GAP)
		else report_problem("idle gap longer than expected before a replay pass");

	done_level: assert property (@(posedge clk) disable iff (reset) done == (pass_idx == NUM_OUT))
		else report_mismatch("done", $sampled(pass_idx == NUM_OUT), $sampled(done));

	result_timing: assert property (@(posedge clk) disable iff (reset) result_valid == last_d[2])
		else report_mismatch("result_valid", $sampled(last_d[2]), $sampled(result_valid));

	result_value: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> longint'(result) == exp_cur)
		else report_mismatch("result", $sampled(exp_cur), $sampled(longint'(result)));

	halted: assert property (@(posedge clk) disable iff (reset)
		(done && res_idx == NUM_OUT) |-> !valid_out && !result_valid)
		else report_problem("output activity after the buffer halted");

	////////////////////
	// Stimulus

	initial begin
		logic [31:0] r;
		lfsr        = 32'h8f91_453c;
		valid_in    = 1'b0;
		in_frame    = 1'b0;
		pxl_in      = '0;
		weight_we   = 1'b0;
		weight_addr = '0;
		weight_data = '0;
		wait (!reset);
		for (int k = 0; k < NUM_OUT; k++) begin
			for (int c = 0; c < NUM_IN; c++) begin
				@(negedge clk);
				draw_bits(`CONV_WEIGHT_WIDTH, r);
				weights[k][c] = conv_pkg::weight_t'(r);
				weight_we     = 1'b1;
				weight_addr   = conv_pkg::weight_addr_t'(k * NUM_IN + c);
				weight_data   = weights[k][c];
			end
		end
		@(negedge clk);
		weight_we = 1'b0;
		// Whole frame on consecutive cycles
		for (int i = 0; i < FRAME; i++) begin
			draw_bits(`CONV_DATA_WIDTH, r);
			frame[i] = conv_pkg::pixel_t'(r);
			valid_in = 1'b1;
			in_frame = 1'b1;
			pxl_in   = frame[i];
			@(negedge clk);
		end
		valid_in = 1'b0;
		in_frame = 1'b0;
		for (int k = 0; k < NUM_OUT; k++)
			exp_res[k] = pass_sum(k);
		wait (done);
		// Stray burst, must be ignored
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			draw_bits(`CONV_DATA_WIDTH, r);
			valid_in = ~i[0];
			pxl_in   = conv_pkg::pixel_t'(r);
		end
		@(negedge clk);
		valid_in = 1'b0;
		repeat (20) @(negedge clk);
		pass_count: assert (pass_idx == NUM_OUT && res_idx == NUM_OUT)
			else report_problem("wrong number of passes or results at the end of the run");
		$display("Error counts: %0d value mismatches, %0d other failures",
			value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not complete", WATCHDOG);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== conv_loop_top.f ====
+incdir+src
src/conv_pkg.sv
src/replay_if.sv
src/single_port_ram.sv
src/feature_loop_buffer.sv
src/pass_accumulator.sv
src/conv_loop_top.sv
testbench/clock_gen.sv
testbench/conv_loop_tb.sv

// ==== Bender.yml ====
package:
  name: conv_loop

sources:
  - include_dirs:
      - src
    files:
      - src/conv_pkg.sv
      - src/replay_if.sv
      - src/single_port_ram.sv
      - src/feature_loop_buffer.sv
      - src/pass_accumulator.sv
      - src/conv_loop_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/clock_gen.sv
      - testbench/conv_loop_tb.sv
